// File: tb.f
+incdir+.
mem_pkg.sv
word_fifo.sv
txrx_buffer.sv
sdram_burst_engine.sv
mem_fault_reg.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

TOP=tb_mem_subsystem
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f tb.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
	exit 0
fi

echo "pass message not found in $LOG"
exit 1

// File: tb_mem_tests.svh
// ----------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------

task automatic reset_values_check();
	test_errs = 0;
	if (ready_write_o !== 1'b1) report_mismatch("ready_write_o", 32'(ready_write_o), 32'd1);
	if (ready_read_o !== 1'b0) report_mismatch("ready_read_o", 32'(ready_read_o), 32'd0);
	if (fault_irq_o !== 1'b0) report_mismatch("fault_irq_o", 32'(fault_irq_o), 32'd0);
	if (exception_bus_o !== '0) report_mismatch("exception_bus_o", 32'(exception_bus_o), 32'd0);
	finish_test("reset_values");
endtask

// one word out and back
task automatic single_write_read();
	word_t w;
	test_errs   = 0;
	single_addr = word_addr_t'(next_rand());
	w           = next_rand();
	ref_mem[single_addr] = w;
	push_word(w);
	issue_req(1'b1, 1'b0, single_addr);
	wait_engine_idle(BUSY_LIMIT);
	issue_req(1'b0, 1'b0, single_addr);
	// issue_req already used one cycle of the bound after req_i
	wait_read_ready(ACCESS_LATENCY + 3);
	if (data_o !== ref_mem[single_addr]) report_mismatch("data_o", data_o, ref_mem[single_addr]);
	pulse_read_ack();
	if (ready_read_o !== 1'b0) report_mismatch("ready_read_o", 32'(ready_read_o), 32'd0);
	wait_engine_idle(BUSY_LIMIT);
	finish_test("single_write_read");
endtask

task automatic block_write_read();
	word_t w;
	word_t exp;
	test_errs  = 0;
	block_addr = word_addr_t'(next_rand());
	for (int i = 0; i < BURST_LEN; i++) begin
		w = next_rand();
		ref_mem[word_addr_t'(block_addr + i)] = w;
		push_word(w);
	end
	// a full burst fills the transmit FIFO
	if (ready_write_o !== 1'b0) report_mismatch("ready_write_o", 32'(ready_write_o), 32'd0);
	issue_req(1'b1, 1'b1, block_addr);
	wait_engine_idle(BUSY_LIMIT);
	if (ready_write_o !== 1'b1) report_mismatch("ready_write_o", 32'(ready_write_o), 32'd1);
	issue_req(1'b0, 1'b1, block_addr);
	for (int i = 0; i < BURST_LEN; i++) begin
		wait_read_ready(ACCESS_LATENCY + 4);
		exp = ref_mem[word_addr_t'(block_addr + i)];
		if (data_o !== exp) report_mismatch("data_o", data_o, exp);
		pulse_read_ack();
	end
	wait_engine_idle(BUSY_LIMIT);
	if (ready_read_o !== 1'b0) report_mismatch("ready_read_o", 32'(ready_read_o), 32'd0);
	finish_test("block_write_read");
endtask

task automatic tx_overflow_fault();
	word_t w;
	fault_t exp_f;
	test_errs = 0;
	ovf_addr  = word_addr_t'(next_rand());
	exp_f     = fault_t'(1) << FAULT_TX_OVERFLOW;
	// last word of FIFO_DEPTH + 1 is dropped
	for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
		w = next_rand();
		if (i < BURST_LEN) begin
			ref_mem[word_addr_t'(ovf_addr + i)] = w;
		end
		push_word(w);
	end
	// pulse is registered and the sticky bit follows one edge later
	@(negedge clock_bus_i);
	if (exception_bus_o !== exp_f) begin
		report_mismatch("exception_bus_o", 32'(exception_bus_o), 32'(exp_f));
	end
	if (fault_irq_o !== 1'b1) report_mismatch("fault_irq_o", 32'(fault_irq_o), 32'd1);
	if (ready_write_o !== 1'b0) report_mismatch("ready_write_o", 32'(ready_write_o), 32'd0);
	pulse_fault_clear();
	if (exception_bus_o !== '0) report_mismatch("exception_bus_o", 32'(exception_bus_o), 32'd0);
	issue_req(1'b1, 1'b1, ovf_addr);
	wait_engine_idle(BUSY_LIMIT);
	if (ready_write_o !== 1'b1) report_mismatch("ready_write_o", 32'(ready_write_o), 32'd1);
	finish_test("tx_overflow");
endtask

task automatic underflow_and_reject();
	fault_t exp_f;
	test_errs = 0;
	exp_f     = fault_t'(1) << FAULT_RX_UNDERFLOW;
	pulse_read_ack();
	@(negedge clock_bus_i);
	if (exception_bus_o !== exp_f) begin
		report_mismatch("exception_bus_o", 32'(exception_bus_o), 32'(exp_f));
	end
	pulse_fault_clear();
	// second strobe lands while the first is still being issued
	issue_req(1'b0, 1'b0, single_addr);
	issue_req(1'b0, 1'b0, word_addr_t'(single_addr + 1));
	// two cycles of the bound went by in the two issue_req calls
	wait_read_ready(ACCESS_LATENCY + 2);
	exp_f = fault_t'(1) << FAULT_REQ_REJECT;
	if (data_o !== ref_mem[single_addr]) report_mismatch("data_o", data_o, ref_mem[single_addr]);
	if (exception_bus_o !== exp_f) begin
		report_mismatch("exception_bus_o", 32'(exception_bus_o), 32'(exp_f));
	end
	pulse_read_ack();
	wait_engine_idle(BUSY_LIMIT);
	if (ready_read_o !== 1'b0) report_mismatch("ready_read_o", 32'(ready_read_o), 32'd0);
	pulse_fault_clear();
	if (exception_bus_o !== '0) report_mismatch("exception_bus_o", 32'(exception_bus_o), 32'd0);
	finish_test("underflow_reject");
endtask

// second burst finds the receive FIFO full
task automatic rx_overflow_fault();
	word_t exp;
	fault_t exp_f;
	test_errs = 0;
	exp_f     = fault_t'(1) << FAULT_RX_OVERFLOW;
	issue_req(1'b0, 1'b1, block_addr);
	wait_engine_idle(BUSY_LIMIT);
	issue_req(1'b0, 1'b1, ovf_addr);
	wait_engine_idle(BUSY_LIMIT);
	if (exception_bus_o !== exp_f) begin
		report_mismatch("exception_bus_o", 32'(exception_bus_o), 32'(exp_f));
	end
	for (int i = 0; i < FIFO_DEPTH; i++) begin
		if (ready_read_o !== 1'b1) report_mismatch("ready_read_o", 32'(ready_read_o), 32'd1);
		exp = ref_mem[word_addr_t'(block_addr + i)];
		if (data_o !== exp) report_mismatch("data_o", data_o, exp);
		pulse_read_ack();
	end
	if (ready_read_o !== 1'b0) report_mismatch("ready_read_o", 32'(ready_read_o), 32'd0);
	pulse_fault_clear();
	finish_test("rx_overflow");
endtask

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem
	import mem_pkg::*;
();

	localparam int FIFO_DEPTH     = 16;
	localparam int BURST_LEN      = 16;
	localparam int MEM_WORDS      = 256;
	localparam int ACCESS_LATENCY = 3;
	// run budget per directed test
	localparam int NUM_TESTS    = 6;
	localparam int TEST_TIME_NS = 2000;
	// cycles an access may keep the engine busy
	localparam int BUSY_LIMIT = 64;

	logic     clock_bus_i;
	logic     reset_i;
	logic     req_i;
	mem_req_t req_data_i;
	logic     write_en_i;
	word_t    data_i;
	logic     read_ack_i;
	logic     fault_clear_i;
	logic     ready_write_o;
	logic     ready_read_o;
	word_t    data_o;
	fault_t   exception_bus_o;
	logic     fault_irq_o;

	// mirror of the storage array
	word_t      ref_mem [MEM_WORDS];
	word_t      rng_state;
	word_addr_t single_addr;
	word_addr_t block_addr;
	word_addr_t ovf_addr;
	int         test_errs;
	int         check_fails;
	int         tests_run;
	int         tests_failed;

	mem_subsystem_top #(
		.FIFO_DEPTH     (FIFO_DEPTH),
		.BURST_LEN      (BURST_LEN),
		.MEM_WORDS      (MEM_WORDS),
		.ACCESS_LATENCY (ACCESS_LATENCY)
	) i_dut (
		.clock_bus_i     (clock_bus_i),
		.reset_i         (reset_i),
		.req_i           (req_i),
		.req_data_i      (req_data_i),
		.write_en_i      (write_en_i),
		.data_i          (data_i),
		.read_ack_i      (read_ack_i),
		.fault_clear_i   (fault_clear_i),
		.ready_write_o   (ready_write_o),
		.ready_read_o    (ready_read_o),
		.data_o          (data_o),
		.exception_bus_o (exception_bus_o),
		.fault_irq_o     (fault_irq_o)
	);

	// 10 ns clock
	always #5 clock_bus_i = ~clock_bus_i;

	// ----------------------------------------------------------------------
	// helpers, all called on a falling edge
	// ----------------------------------------------------------------------

	// xorshift32 step
	function automatic word_t next_rand();
		word_t x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		$display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
		test_errs++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		check_fails += test_errs;
		if (test_errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_errs);
			tests_failed++;
		end
	endtask

	task automatic push_word(input word_t w);
		write_en_i = 1'b1;
		data_i     = w;
		@(negedge clock_bus_i);
		write_en_i = 1'b0;
	endtask

	// one-cycle request strobe
	task automatic issue_req(input logic rw, input logic blk, input word_addr_t addr);
		req_i            = 1'b1;
		req_data_i.rw    = rw;
		req_data_i.block = blk;
		req_data_i.addr  = addr;
		@(negedge clock_bus_i);
		req_i = 1'b0;
	endtask

	task automatic pulse_read_ack();
		read_ack_i = 1'b1;
		@(negedge clock_bus_i);
		read_ack_i = 1'b0;
	endtask

	task automatic pulse_fault_clear();
		fault_clear_i = 1'b1;
		@(negedge clock_bus_i);
		fault_clear_i = 1'b0;
	endtask

	task automatic wait_read_ready(input int bound);
		int n;
		n = 0;
		while (!ready_read_o && n < bound) begin
			@(negedge clock_bus_i);
			n++;
		end
		if (!ready_read_o) begin
			$display("t=%0t no read word arrived within %0d cycles", $time, bound);
			test_errs++;
		end
	endtask

	// engine has captured the request one edge after the strobe
	task automatic wait_engine_idle(input int bound);
		int n;
		n = 0;
		@(negedge clock_bus_i);
		while (!i_dut.mem_ready && n < bound) begin
			@(negedge clock_bus_i);
			n++;
		end
		if (!i_dut.mem_ready) begin
			$display("t=%0t engine still busy after %0d cycles", $time, bound);
			test_errs++;
		end
	endtask

	`include "tb_mem_tests.svh"

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------

	initial begin
		clock_bus_i   = 1'b0;
		reset_i       = 1'b0;
		req_i         = 1'b0;
		req_data_i    = '0;
		write_en_i    = 1'b0;
		data_i        = '0;
		read_ack_i    = 1'b0;
		fault_clear_i = 1'b0;
		rng_state     = 32'hd2d7_cbd4;
		test_errs     = 0;
		check_fails   = 0;
		tests_run     = 0;
		tests_failed  = 0;
		// reset held for 5 rising edges
		repeat (5) @(posedge clock_bus_i);
		@(negedge clock_bus_i);
		reset_i = 1'b1;
		reset_values_check();
		single_write_read();
		block_write_read();
		tx_overflow_fault();
		underflow_and_reject();
		rx_overflow_fault();
		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, check_fails);
		if (check_fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(NUM_TESTS * TEST_TIME_NS);
		$display("watchdog expired after %0d ns, run did not complete",
			NUM_TESTS * TEST_TIME_NS);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top
	import mem_pkg::*;
#(
	parameter int FIFO_DEPTH     = 16,
	parameter int BURST_LEN      = 16,
	parameter int MEM_WORDS      = 256,
	parameter int ACCESS_LATENCY = 3
) (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  logic     req_i,
	input  mem_req_t req_data_i,
	input  logic     write_en_i,
	input  word_t    data_i,
	input  logic     read_ack_i,
	input  logic     fault_clear_i,
	output logic     ready_write_o,
	output logic     ready_read_o,
	output word_t    data_o,
	output fault_t   exception_bus_o,
	output logic     fault_irq_o
);

	// buffer to engine
	logic     mem_req;
	mem_req_t mem_req_data;
	logic     mem_wvalid;
	word_t    mem_wdata;
	logic     mem_clear;
	// engine to buffer
	logic     mem_ready;
	logic     mem_valid;
	word_t    mem_rdata;
	logic     mem_done;
	// fault pulses
	fault_t   fault_set;

	// ----------------------------------------------------------------------
	// controller side queues
	// ----------------------------------------------------------------------

	txrx_buffer #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BURST_LEN  (BURST_LEN)
	) u_txrx_buffer (
		.clock_bus_i    (clock_bus_i),
		.reset_i        (reset_i),
		.req_i          (req_i),
		.req_data_i     (req_data_i),
		.write_en_i     (write_en_i),
		.data_i         (data_i),
		.read_ack_i     (read_ack_i),
		.ready_write_o  (ready_write_o),
		.ready_read_o   (ready_read_o),
		.data_o         (data_o),
		.mem_req_o      (mem_req),
		.mem_req_data_o (mem_req_data),
		.mem_wvalid_o   (mem_wvalid),
		.mem_wdata_o    (mem_wdata),
		.mem_clear_o    (mem_clear),
		.mem_ready_i    (mem_ready),
		.mem_valid_i    (mem_valid),
		.mem_rdata_i    (mem_rdata),
		.mem_done_i     (mem_done),
		.fault_set_o    (fault_set)
	);

	// storage side
	sdram_burst_engine #(
		.BURST_LEN      (BURST_LEN),
		.MEM_WORDS      (MEM_WORDS),
		.ACCESS_LATENCY (ACCESS_LATENCY)
	) u_sdram_burst_engine (
		.clock_bus_i    (clock_bus_i),
		.reset_i        (reset_i),
		.mem_req_i      (mem_req),
		.mem_req_data_i (mem_req_data),
		.mem_wvalid_i   (mem_wvalid),
		.mem_wdata_i    (mem_wdata),
		.mem_clear_i    (mem_clear),
		.mem_ready_o    (mem_ready),
		.mem_valid_o    (mem_valid),
		.mem_rdata_o    (mem_rdata),
		.mem_done_o     (mem_done)
	);

	// fault collection
	mem_fault_reg u_mem_fault_reg (
		.clock_bus_i     (clock_bus_i),
		.reset_i         (reset_i),
		.fault_set_i     (fault_set),
		.fault_clear_i   (fault_clear_i),
		.exception_bus_o (exception_bus_o),
		.fault_irq_o     (fault_irq_o)
	);

endmodule

// File: mem_fault_reg.sv
`timescale 1ns/1ps

module mem_fault_reg
	import mem_pkg::*;
(
	input  logic   clock_bus_i,
	input  logic   reset_i,
	input  fault_t fault_set_i,
	input  logic   fault_clear_i,
	output fault_t exception_bus_o,
	output logic   fault_irq_o
);

	fault_t sticky_q;
	fault_t keep;

	// ----------------------------------------------------------------------
	// sticky bits
	// ----------------------------------------------------------------------

	// clear drops held bits only
	assign keep = fault_clear_i ? '0 : sticky_q;

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			sticky_q <= '0;
		end else begin
			// new pulses land even during a clear
			sticky_q <= keep | fault_set_i;
		end
	end

	assign exception_bus_o = sticky_q;

	// interrupt while any fault is held
	assign fault_irq_o = |sticky_q;

endmodule

// File: sdram_burst_engine.sv
`timescale 1ns/1ps

module sdram_burst_engine
	import mem_pkg::*;
#(
	parameter int BURST_LEN      = 16,
	parameter int MEM_WORDS      = 256,
	parameter int ACCESS_LATENCY = 3
) (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  logic     mem_req_i,
	input  mem_req_t mem_req_data_i,
	input  logic     mem_wvalid_i,
	input  word_t    mem_wdata_i,
	input  logic     mem_clear_i,
	output logic     mem_ready_o,
	output logic     mem_valid_o,
	output word_t    mem_rdata_o,
	output logic     mem_done_o
);

	localparam int MAW = $clog2(MEM_WORDS);
	localparam int CW  = $clog2(BURST_LEN + 1);
	localparam int LW  = $clog2(ACCESS_LATENCY + 1);

	typedef enum logic [2:0] {
		st_idle,
		st_lat_wait,
		st_read_burst,
		st_write_collect,
		st_done,
		st_wait_clear
	} eng_state_t;

	eng_state_t      state_q;
	mem_req_t        req_q;
	logic [CW-1:0]   idx_q;
	logic [CW-1:0]   last_idx;
	logic [LW-1:0]   lat_q;
	logic [MAW-1:0]  word_addr;
	word_t           storage_q [MEM_WORDS];

	// ----------------------------------------------------------------------
	// addressing
	// ----------------------------------------------------------------------

	// single access ends on index 0
	assign last_idx  = req_q.block ? CW'(BURST_LEN - 1) : '0;
	// start plus index, wraps at the array size
	assign word_addr = MAW'((int'(req_q.addr) + int'(idx_q)) % MEM_WORDS);

	// idle is the only state that takes a request
	assign mem_ready_o = (state_q == st_idle);

	// storage, captured request and read data
	always_ff @(posedge clock_bus_i) begin
		if (state_q == st_idle && mem_req_i) begin
			req_q <= mem_req_data_i;
		end
		if (state_q == st_write_collect && mem_wvalid_i) begin
			storage_q[word_addr] <= mem_wdata_i;
		end
		if (state_q == st_read_burst) begin
			mem_rdata_o <= storage_q[word_addr];
		end
	end

	// ----------------------------------------------------------------------
	// access FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			state_q     <= st_idle;
			idx_q       <= '0;
			lat_q       <= '0;
			mem_valid_o <= 1'b0;
			mem_done_o  <= 1'b0;
		end else begin
			// strobes default low
			mem_valid_o <= 1'b0;
			mem_done_o  <= 1'b0;
			case (state_q)
				st_idle: begin
					if (mem_req_i) begin
						idx_q   <= '0;
						lat_q   <= LW'(ACCESS_LATENCY - 1);
						state_q <= mem_req_data_i.rw ? st_write_collect : st_lat_wait;
					end
				end
				st_lat_wait: begin
					// fixed array access delay
					if (lat_q <= LW'(1)) begin
						state_q <= st_read_burst;
					end else begin
						lat_q <= lat_q - 1'b1;
					end
				end
				st_read_burst: begin
					mem_valid_o <= 1'b1;
					idx_q       <= idx_q + 1'b1;
					if (idx_q == last_idx) begin
						state_q <= st_done;
					end
				end
				st_write_collect: begin
					// pace set by the transmit side
					if (mem_wvalid_i) begin
						idx_q <= idx_q + 1'b1;
						if (idx_q == last_idx) begin
							mem_done_o <= 1'b1;
							state_q    <= st_wait_clear;
						end
					end
				end
				st_done: begin
					// last read word on the bus this cycle
					mem_done_o <= 1'b1;
					state_q    <= st_wait_clear;
				end
				st_wait_clear: begin
					if (mem_clear_i) begin
						state_q <= st_idle;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	a_valid_done : assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		!(mem_valid_o && mem_done_o));

	// buffer answers every done with a clear
	a_done_clear : assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		mem_done_o |=> mem_clear_i);

endmodule

// File: txrx_buffer.sv
`timescale 1ns/1ps

module txrx_buffer
	import mem_pkg::*;
#(
	parameter int FIFO_DEPTH = 16,
	parameter int BURST_LEN  = 16
) (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	// controller side
	input  logic     req_i,
	input  mem_req_t req_data_i,
	input  logic     write_en_i,
	input  word_t    data_i,
	input  logic     read_ack_i,
	output logic     ready_write_o,
	output logic     ready_read_o,
	output word_t    data_o,
	// engine side
	output logic     mem_req_o,
	output mem_req_t mem_req_data_o,
	output logic     mem_wvalid_o,
	output word_t    mem_wdata_o,
	output logic     mem_clear_o,
	input  logic     mem_ready_i,
	input  logic     mem_valid_i,
	input  word_t    mem_rdata_i,
	input  logic     mem_done_i,
	// fault pulses
	output fault_t   fault_set_o
);

	localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;
	localparam int TW    = $clog2(BURST_LEN + 1);

	logic [CNT_W-1:0] tx_count;
	logic [CNT_W-1:0] rx_count;
	logic             tx_full;
	logic             tx_empty;
	logic             rx_full;
	logic             rx_empty;
	word_t            tx_head;
	logic             req_accept;
	logic             tx_send;
	logic [TW-1:0]    xfer_q;
	fault_t           fault_d;

	// ----------------------------------------------------------------------
	// queues
	// ----------------------------------------------------------------------

	// outgoing write words drained toward the engine
	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.push_i      (write_en_i),
		.pop_i       (tx_send),
		.push_data_i (data_i),
		.pop_data_o  (tx_head),
		.count_o     (tx_count),
		.full_o      (tx_full),
		.empty_o     (tx_empty)
	);

	// returned read words drained by read_ack
	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.push_i      (mem_valid_i),
		.pop_i       (read_ack_i),
		.push_data_i (mem_rdata_i),
		.pop_data_o  (data_o),
		.count_o     (rx_count),
		.full_o      (rx_full),
		.empty_o     (rx_empty)
	);

	assign ready_write_o = (tx_count < CNT_W'(FIFO_DEPTH));
	assign ready_read_o  = (rx_count != '0);

	// ----------------------------------------------------------------------
	// request issue and write drain
	// ----------------------------------------------------------------------

	// engine still shows ready in the cycle of mem_req_o, so mask it
	assign req_accept = req_i && mem_ready_i && !mem_req_o;
	// one word per cycle while the transfer count remains
	assign tx_send    = (xfer_q != '0) && !tx_empty;

	// one fault bit per condition
	always_comb begin
		fault_d                     = '0;
		fault_d[FAULT_TX_OVERFLOW]  = write_en_i && tx_full;
		fault_d[FAULT_RX_OVERFLOW]  = mem_valid_i && rx_full;
		fault_d[FAULT_RX_UNDERFLOW] = read_ack_i && rx_empty;
		fault_d[FAULT_REQ_REJECT]   = req_i && !req_accept;
	end

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			mem_req_o    <= 1'b0;
			mem_wvalid_o <= 1'b0;
			mem_clear_o  <= 1'b0;
			xfer_q       <= '0;
			fault_set_o  <= '0;
		end else begin
			mem_req_o    <= req_accept;
			mem_wvalid_o <= tx_send;
			// release the engine one cycle after done
			mem_clear_o  <= mem_done_i;
			fault_set_o  <= fault_d;
			if (req_accept && req_data_i.rw) begin
				xfer_q <= req_data_i.block ? TW'(BURST_LEN) : TW'(1);
			end else if (tx_send) begin
				xfer_q <= xfer_q - 1'b1;
			end
		end
	end

	// request and write payload
	always_ff @(posedge clock_bus_i) begin
		if (req_accept) begin
			mem_req_data_o <= req_data_i;
		end
		if (tx_send) begin
			mem_wdata_o <= tx_head;
		end
	end

	// engine must still be idle when it sees the strobe
	a_req_idle : assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		mem_req_o |-> mem_ready_i);

endmodule

// File: word_fifo.sv
`timescale 1ns/1ps

module word_fifo
	import mem_pkg::*;
#(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                        clock_bus_i,
	input  logic                        reset_i,
	input  logic                        push_i,
	input  logic                        pop_i,
	input  word_t                       push_data_i,
	output word_t                       pop_data_o,
	output logic [$clog2(FIFO_DEPTH):0] count_o,
	output logic                        full_o,
	output logic                        empty_o
);

	localparam int AW = $clog2(FIFO_DEPTH);

	word_t          mem_q [FIFO_DEPTH];
	logic [AW-1:0]  wr_ptr_q;
	logic [AW-1:0]  rd_ptr_q;
	logic [AW:0]    count_q;
	logic           do_push;
	logic           do_pop;

	// push dropped when full, pop dropped when empty
	assign full_o  = (count_q == (AW+1)'(FIFO_DEPTH));
	assign empty_o = (count_q == '0);
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	// head of queue always visible
	assign pop_data_o = mem_q[rd_ptr_q];
	assign count_o    = count_q;

	// storage
	always_ff @(posedge clock_bus_i) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= push_data_i;
		end
	end

	// pointers wrap at the power-of-two depth
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	a_count_bound : assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		count_q <= (AW+1)'(FIFO_DEPTH));

	// pointer distance tracks occupancy modulo depth
	a_ptr_count : assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		AW'(wr_ptr_q - rd_ptr_q) == count_q[AW-1:0]);

endmodule

// File: mem_pkg.sv
package mem_pkg;

	// ----------------------------------------------------------------------
	// word and address types
	// ----------------------------------------------------------------------

	// word address width, covers the whole storage array
	localparam int BW_WORD_ADDR = 8;

	// one data word on every bus of the subsystem
	typedef logic [31:0] word_t;

	// word address, no byte lanes
	typedef logic [BW_WORD_ADDR-1:0] word_addr_t;

	// ----------------------------------------------------------------------
	// request descriptor
	// ----------------------------------------------------------------------

	// rw: 1 write, 0 read
	// block: 1 burst of BURST_LEN words, 0 single word
	// addr: first word of the access
	typedef struct packed {
		logic       rw;
		logic       block;
		word_addr_t addr;
	} mem_req_t;

	// ----------------------------------------------------------------------
	// fault reporting
	// ----------------------------------------------------------------------

	// one bit per fault source
	typedef logic [3:0] fault_t;

	// write word pushed into a full transmit FIFO
	localparam int FAULT_TX_OVERFLOW = 0;

	// read word returned into a full receive FIFO
	localparam int FAULT_RX_OVERFLOW = 1;

	// read_ack with nothing in the receive FIFO
	localparam int FAULT_RX_UNDERFLOW = 2;

	// request while the engine is busy
	localparam int FAULT_REQ_REJECT = 3;

endpackage
